// ==== Makefile ====
SIM      ?= verilator
TOP      ?= spm_tb
FILELIST ?= verilog.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"

# exit status of the simulation binary is the test result
test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/spm_pkg.sv ====
// shared opcode and status enums plus default scratchpad geometry, imported by rtl and testbench
package spm_pkg;

    // default geometry, top level overrides through its own parameters
    localparam int SPM_DATA_W  = 32;  // word width in bits
    localparam int SPM_ELS     = 64;  // total words
    localparam int SPM_CREDITS = 2;   // queue depth == credits held by requester

    // request opcode
    typedef enum logic {
        SPM_OP_READ  = 1'b0,
        SPM_OP_WRITE = 1'b1
    } spm_op_e;

    // response status
    // locked only ever comes back for a write below the lock limit
    typedef enum logic {
        SPM_STATUS_OK     = 1'b0,
        SPM_STATUS_LOCKED = 1'b1
    } spm_status_e;

endpackage

// ==== dv/spm_sva.sv ====
// concurrent checks on credit return, queue bound and response timing, bound into spm_req_ctrl
`timescale 1ns/1ns

module spm_sva #(
    parameter int  CREDITS = spm_pkg::SPM_CREDITS,
    localparam int CNT_W   = $clog2(CREDITS + 1)
) (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             req_v_i,   // request written into the queue
    input logic             credit_i,  // controller credit_o
    input logic             mem_v_i,   // issue strobe
    input logic             resp_v_i,
    input logic [CNT_W-1:0] count_i    // queue occupancy
);

    logic [CNT_W-1:0] held_q;  // requests accepted and not yet credited back

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held_q <= '0;
        end else begin
            held_q <= held_q + CNT_W'(req_v_i) - CNT_W'(credit_i);
        end
    end

    // a credit only comes back on an issue of a request still held
    a_credit_per_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_i |-> mem_v_i && (held_q != '0))
        else $error("credit pulse without a matching issued request");

    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_i <= CNT_W'(CREDITS))
        else $error("queue holds more entries than credits");

    // memory latency is one cycle, response lines up with it
    a_resp_after_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_v_i |=> resp_v_i)
        else $error("no response one cycle after issue");

    a_resp_has_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resp_v_i |-> $past(mem_v_i))
        else $error("response without an issue the cycle before");

endmodule

bind spm_req_ctrl spm_sva #(.CREDITS (CREDITS)) u_sva (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .req_v_i (req_v_i), .credit_i (credit_o),
    .mem_v_i (mem_v_o), .resp_v_i (resp_v_o), .count_i (count_q)
);

// ==== dv/spm_tb.sv ====
// self-checking testbench for the banked scratchpad, runs a request table against a reference model
`timescale 1ns/1ns

module spm_tb;
    import spm_pkg::*;

    localparam int ADDR_W      = $clog2(SPM_ELS);
    localparam int MASK_W      = SPM_DATA_W / 8;
    localparam int NUM_ENTRIES = 21;
    localparam int MAX_CYCLES  = NUM_ENTRIES * 10 + 100;  // run limit in clock cycles

    typedef struct packed {
        spm_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [MASK_W-1:0] mask;
        logic              set_lock;  // load lock limit before this request
        logic [ADDR_W-1:0] lock;
        spm_status_e       status;    // expected status
    } entry_t;

    typedef struct packed {
        int                    idx;
        spm_op_e               op;
        spm_status_e           status;
        logic [SPM_DATA_W-1:0] data;
    } exp_t;

    // depth bank is addr[1:0], so 10/05/0a/0f hit all four
    localparam entry_t TABLE [NUM_ENTRIES] = '{
        '{SPM_OP_WRITE, 6'h10, 4'hf, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h05, 4'hf, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h0a, 4'hf, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h0f, 4'hf, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_READ,  6'h10, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_READ,  6'h05, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_READ,  6'h0a, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_READ,  6'h0f, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h05, 4'h5, 1'b0, 6'h00, SPM_STATUS_OK},      // bytes 0 and 2
        '{SPM_OP_READ,  6'h05, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h0a, 4'h8, 1'b0, 6'h00, SPM_STATUS_OK},      // upper width bank only
        '{SPM_OP_READ,  6'h0a, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h10, 4'hf, 1'b1, 6'h20, SPM_STATUS_LOCKED},  // lock below 0x20
        '{SPM_OP_READ,  6'h10, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h20, 4'hf, 1'b0, 6'h00, SPM_STATUS_OK},      // at the limit
        '{SPM_OP_READ,  6'h20, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h05, 4'hf, 1'b0, 6'h00, SPM_STATUS_LOCKED},
        '{SPM_OP_READ,  6'h05, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h3f, 4'hf, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_READ,  6'h3f, 4'h0, 1'b0, 6'h00, SPM_STATUS_OK},
        '{SPM_OP_WRITE, 6'h1f, 4'hf, 1'b0, 6'h00, SPM_STATUS_LOCKED}
    };

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  req_v_i;
    spm_op_e               req_op_i;
    logic [ADDR_W-1:0]     req_addr_i;
    logic [SPM_DATA_W-1:0] req_wdata_i;
    logic [MASK_W-1:0]     req_mask_i;
    logic                  credit_o;
    logic                  resp_v_o;
    spm_op_e               resp_op_o;
    spm_status_e           resp_status_o;
    logic [SPM_DATA_W-1:0] resp_rdata_o;
    logic                  cfg_we_i;
    logic [ADDR_W-1:0]     cfg_lock_i;
    logic [15:0]           cfg_reject_cnt_o;

    logic [SPM_DATA_W-1:0] ref_mem [SPM_ELS];  // reference memory
    exp_t                  exp_q [$];          // outstanding responses, request order
    int                    credits;            // credits held by the requester
    int                    rejects;            // locked writes answered so far
    int                    cycles = 0;
    logic                  seen_req;           // low until the first request after reset

    spm_top dut (
        .clk_i, .rst_n_i, .req_v_i, .req_op_i, .req_addr_i, .req_wdata_i, .req_mask_i,
        .credit_o, .resp_v_o, .resp_op_o, .resp_status_o, .resp_rdata_o,
        .cfg_we_i, .cfg_lock_i, .cfg_reject_cnt_o
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("*** FAILED ***");
        $fatal(1, "%s", why);
    endtask

    function automatic string test_name(input int idx);
        return (idx < NUM_ENTRIES) ? $sformatf("entry %0d", idx) : "read after reset";
    endfunction

    task automatic check_op(input string name, input spm_op_e expected,
                            input spm_op_e actual);
        if (actual !== expected) begin
            $display("error %s op expected %s actual %s", name, expected.name(),
                     actual.name());
            abort_run("response opcode mismatch");
        end
    endtask

    task automatic check_status(input string name, input spm_status_e expected,
                                input spm_status_e actual);
        if (actual !== expected) begin
            $display("error %s status expected %s actual %s", name, expected.name(),
                     actual.name());
            abort_run("response status mismatch");
        end
    endtask

    task automatic check_data(input string name, input logic [SPM_DATA_W-1:0] expected,
                              input logic [SPM_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("error %s data expected %08h actual %08h", name, expected, actual);
            abort_run("read data mismatch");
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("error %s reject count expected %0d actual %0d", name, expected, actual);
            abort_run("reject counter mismatch");
        end
    endtask

    // hold reset 4 cycles, requester gets its credits back
    task automatic reset_dut();
        rst_n_i  = 1'b0;
        seen_req = 1'b0;
        credits  = SPM_CREDITS;
        rejects  = 0;
        repeat (4) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;
        repeat (2) @(posedge clk_i);  // idle, credit and resp must stay low
        #10;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #10;
        end
    endtask

    // drained first so no queued request sees the new limit
    task automatic load_lock(input logic [ADDR_W-1:0] limit);
        wait_drain();
        cfg_we_i   = 1'b1;
        cfg_lock_i = limit;
        @(posedge clk_i);
        #10;
        cfg_we_i = 1'b0;
    endtask

    task automatic send_req(input int idx, input spm_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [MASK_W-1:0] mask, input spm_status_e status);
        logic [SPM_DATA_W-1:0] wdata;
        exp_t                  e;
        while (credits == 0) begin  // out of credits, wait for a return
            @(posedge clk_i);
            #10;
        end
        wdata    = $urandom;
        e.idx    = idx;
        e.op     = op;
        e.status = status;
        e.data   = ref_mem[addr];  // earlier writes already merged
        if (op == SPM_OP_WRITE && status == SPM_STATUS_OK) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (mask[b]) ref_mem[addr][b*8 +: 8] = wdata[b*8 +: 8];  // byte-mask merge
            end
        end
        req_v_i     = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        req_mask_i  = mask;
        credits--;
        seen_req = 1'b1;
        exp_q.push_back(e);
        @(posedge clk_i);
        #10;
        req_v_i = 1'b0;
    endtask

    // responses and credits sampled mid-cycle
    always @(negedge clk_i) begin : monitor
        exp_t e;
        if (credit_o) credits++;
        if (!seen_req && (credit_o || resp_v_o)) begin
            abort_run("credit or response seen before any request");
        end else if (resp_v_o) begin
            if (exp_q.size() == 0) begin
                abort_run("response arrived with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                if (e.status == SPM_STATUS_LOCKED) rejects++;
                check_op(test_name(e.idx), e.op, resp_op_o);
                check_status(test_name(e.idx), e.status, resp_status_o);
                if (e.op == SPM_OP_READ && e.status == SPM_STATUS_OK) begin
                    check_data(test_name(e.idx), e.data, resp_rdata_o);
                end
                check_count(test_name(e.idx), 16'(rejects), cfg_reject_cnt_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) abort_run("timeout waiting for response");
    end

    initial begin
        void'($urandom(30831));
        req_v_i     = 1'b0;
        req_op_i    = SPM_OP_READ;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_mask_i  = '0;
        cfg_we_i    = 1'b0;
        cfg_lock_i  = '0;
        reset_dut();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (TABLE[i].set_lock) load_lock(TABLE[i].lock);
            send_req(i, TABLE[i].op, TABLE[i].addr, TABLE[i].mask, TABLE[i].status);
        end
        wait_drain();
        reset_dut();  // storage has no reset, contents survive
        send_req(NUM_ENTRIES, SPM_OP_READ, 6'h20, '0, SPM_STATUS_OK);
        wait_drain();
        if (credits != SPM_CREDITS) begin  // every issue hands its credit back
            abort_run("credits not all returned at end of test");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== sram/spm_bank.sv ====
// single-port synchronous sram bank with byte write mask, used as one tile of the banked memory
`timescale 1ns/1ns

module spm_bank #(
    parameter int  DATA_W = spm_pkg::SPM_DATA_W,
    parameter int  ELS    = spm_pkg::SPM_ELS,
    localparam int ADDR_W = (ELS > 1) ? $clog2(ELS) : 1,
    localparam int MASK_W = DATA_W / 8
) (
    input  logic              clk_i,
    input  logic              v_i,     // bank enable
    input  logic              w_i,     // 1 = write, 0 = read
    input  logic [ADDR_W-1:0] addr_i,  // word address within the bank
    input  logic [DATA_W-1:0] data_i,
    input  logic [MASK_W-1:0] mask_i,  // one bit per byte lane
    output logic [DATA_W-1:0] data_o   // registered read word
);

    logic [DATA_W-1:0] mem_q [ELS];  // storage array
    logic [DATA_W-1:0] rdata_q;

    // byte-lane writes
    always_ff @(posedge clk_i) begin
        if (v_i && w_i) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (mask_i[b]) begin
                    mem_q[addr_i][b*8 +: 8] <= data_i[b*8 +: 8];
                end
            end
        end
    end

    // read port, holds last read word across writes and idle cycles
    always_ff @(posedge clk_i) begin
        if (v_i && !w_i) begin
            rdata_q <= mem_q[addr_i];
        end
    end

    assign data_o = rdata_q;

endmodule

// ==== sram/spm_banked_mem.sv ====
// scratchpad storage split into width and depth banks, only one depth bank enabled per access
`timescale 1ns/1ns

module spm_banked_mem #(
    parameter int  DATA_W               = spm_pkg::SPM_DATA_W,
    parameter int  ELS                  = spm_pkg::SPM_ELS,
    parameter int  NUM_WIDTH_BANKS      = 2,
    parameter int  NUM_DEPTH_BANKS      = 4,
    parameter int  DEPTH_BANK_START_IDX = 0,  // lowest addr bit of the depth-bank index
    localparam int ADDR_W               = $clog2(ELS),
    localparam int MASK_W               = DATA_W / 8
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              v_i,
    input  logic              w_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] data_i,
    input  logic [MASK_W-1:0] mask_i,
    output logic [DATA_W-1:0] data_o  // valid the cycle after a read
);

    localparam int BANK_W      = DATA_W / NUM_WIDTH_BANKS;  // bits per width bank
    localparam int BANK_MASK_W = BANK_W / 8;
    localparam int BANK_ELS    = ELS / NUM_DEPTH_BANKS;      // words per depth bank

    if (NUM_DEPTH_BANKS == 1) begin : g_db1
        // no depth split, full address goes straight to every width bank
        for (genvar i = 0; i < NUM_WIDTH_BANKS; i++) begin : g_wb
            spm_bank #(
                .DATA_W (BANK_W),
                .ELS    (BANK_ELS)
            ) u_bank (
                .clk_i  (clk_i),
                .v_i    (v_i),
                .w_i    (w_i),
                .addr_i (addr_i),
                .data_i (data_i[i*BANK_W +: BANK_W]),
                .mask_i (mask_i[i*BANK_MASK_W +: BANK_MASK_W]),
                .data_o (data_o[i*BANK_W +: BANK_W])
            );
        end
    end else begin : g_dbn
        localparam int IDX_W       = $clog2(NUM_DEPTH_BANKS);
        localparam int BANK_ADDR_W = $clog2(BANK_ELS);

        logic [IDX_W-1:0]       bank_idx;                    // selected depth bank
        logic [IDX_W-1:0]       bank_idx_q;                  // depth bank of the last read
        logic [BANK_ADDR_W-1:0] bank_addr;                   // address left after index removal
        logic [NUM_DEPTH_BANKS-1:0] bank_v;                  // one-hot enables
        logic [DATA_W-1:0]      bank_data [NUM_DEPTH_BANKS];

        assign bank_idx = addr_i[DEPTH_BANK_START_IDX +: IDX_W];

        // close up the address bits around the index field
        if (DEPTH_BANK_START_IDX == 0) begin : g_lsb
            assign bank_addr = addr_i[IDX_W +: BANK_ADDR_W];
        end else if (DEPTH_BANK_START_IDX == ADDR_W - IDX_W) begin : g_msb
            assign bank_addr = addr_i[0 +: BANK_ADDR_W];
        end else begin : g_mid
            assign bank_addr = {addr_i[ADDR_W-1:DEPTH_BANK_START_IDX+IDX_W],
                                addr_i[DEPTH_BANK_START_IDX-1:0]};
        end

        for (genvar j = 0; j < NUM_DEPTH_BANKS; j++) begin : g_db
            assign bank_v[j] = v_i && (bank_idx == IDX_W'(j));  // decode with valid

            for (genvar i = 0; i < NUM_WIDTH_BANKS; i++) begin : g_wb
                spm_bank #(
                    .DATA_W (BANK_W),
                    .ELS    (BANK_ELS)
                ) u_bank (
                    .clk_i  (clk_i),
                    .v_i    (bank_v[j]),
                    .w_i    (w_i),
                    .addr_i (bank_addr),
                    .data_i (data_i[i*BANK_W +: BANK_W]),
                    .mask_i (mask_i[i*BANK_MASK_W +: BANK_MASK_W]),
                    .data_o (bank_data[j][i*BANK_W +: BANK_W])
                );
            end
        end

        // remember which depth bank answers next cycle
        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                bank_idx_q <= '0;
            end else if (v_i && !w_i) begin
                bank_idx_q <= bank_idx;
            end
        end

        assign data_o = bank_data[bank_idx_q];  // read-data mux
    end

endmodule

// ==== verilog.f ====
common/spm_pkg.sv
sram/spm_bank.sv
sram/spm_banked_mem.sv
verilog/spm_req_ctrl.sv
verilog/spm_cfg_regs.sv
verilog/spm_top.sv
dv/spm_sva.sv
dv/spm_tb.sv

// ==== verilog/spm_cfg_regs.sv ====
// scratchpad config registers, lock limit for writes and a saturating rejected-write counter
`timescale 1ns/1ns

module spm_cfg_regs #(
    parameter int  ELS    = spm_pkg::SPM_ELS,
    localparam int ADDR_W = $clog2(ELS)
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              cfg_we_i,          // one-cycle load strobe
    input  logic [ADDR_W-1:0] cfg_lock_i,
    input  logic              reject_i,          // from the request controller
    output logic [ADDR_W-1:0] lock_limit_o,
    output logic [15:0]       cfg_reject_cnt_o
);

    logic [ADDR_W-1:0] lock_limit_q;  // zero means nothing locked
    logic [15:0]       reject_cnt_q;

    // new limit visible the cycle after the strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lock_limit_q <= '0;
        end else if (cfg_we_i) begin
            lock_limit_q <= cfg_lock_i;
        end
    end

    // count rejects, stick at all ones
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reject_cnt_q <= '0;
        end else if (reject_i && (reject_cnt_q != 16'hffff)) begin
            reject_cnt_q <= reject_cnt_q + 16'd1;
        end
    end

    assign lock_limit_o     = lock_limit_q;
    assign cfg_reject_cnt_o = reject_cnt_q;

endmodule

// ==== verilog/spm_req_ctrl.sv ====
// credit-guarded request queue for the scratchpad, issues to memory and builds in-order responses
`timescale 1ns/1ns

module spm_req_ctrl #(
    parameter int  DATA_W  = spm_pkg::SPM_DATA_W,
    parameter int  ELS     = spm_pkg::SPM_ELS,
    parameter int  CREDITS = spm_pkg::SPM_CREDITS,
    localparam int ADDR_W  = $clog2(ELS),
    localparam int MASK_W  = DATA_W / 8
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_v_i,        // only while requester holds a credit
    input  spm_pkg::spm_op_e     req_op_i,
    input  logic [ADDR_W-1:0]    req_addr_i,
    input  logic [DATA_W-1:0]    req_wdata_i,
    input  logic [MASK_W-1:0]    req_mask_i,
    input  logic [ADDR_W-1:0]    lock_limit_i,   // writes below this are dropped
    input  logic [DATA_W-1:0]    mem_rdata_i,
    output logic                 credit_o,       // one pulse per issue
    output logic                 reject_o,       // one pulse per locked write
    output logic                 mem_v_o,
    output logic                 mem_w_o,
    output logic [ADDR_W-1:0]    mem_addr_o,
    output logic [DATA_W-1:0]    mem_wdata_o,
    output logic [MASK_W-1:0]    mem_mask_o,
    output logic                 resp_v_o,
    output spm_pkg::spm_op_e     resp_op_o,
    output spm_pkg::spm_status_e resp_status_o,
    output logic [DATA_W-1:0]    resp_rdata_o    // only meaningful for an ok read
);
    import spm_pkg::*;

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    // queue payload
    spm_op_e           op_q    [CREDITS];
    logic [ADDR_W-1:0] addr_q  [CREDITS];
    logic [DATA_W-1:0] wdata_q [CREDITS];
    logic [MASK_W-1:0] mask_q  [CREDITS];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;   // entries held, bounded by credits
    logic              issue;     // head goes to memory this cycle
    logic              locked;    // head is a write inside the locked range
    logic              resp_v_q;
    spm_op_e           resp_op_q;
    spm_status_e       resp_status_q;

    // circular pointer step
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign issue  = (count_q != '0);
    assign locked = (op_q[rd_ptr_q] == SPM_OP_WRITE) && (addr_q[rd_ptr_q] < lock_limit_i);

    always_ff @(posedge clk_i) begin
        if (req_v_i) begin
            op_q[wr_ptr_q]    <= req_op_i;
            addr_q[wr_ptr_q]  <= req_addr_i;
            wdata_q[wr_ptr_q] <= req_wdata_i;
            mask_q[wr_ptr_q]  <= req_mask_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            resp_v_q <= 1'b0;
        end else begin
            if (req_v_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (issue) rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q  <= count_q + CNT_W'(req_v_i) - CNT_W'(issue);
            resp_v_q <= issue;  // memory answers one cycle later
        end
    end

    // op and status ride alongside the memory access
    always_ff @(posedge clk_i) begin
        if (issue) begin
            resp_op_q     <= op_q[rd_ptr_q];
            resp_status_q <= locked ? SPM_STATUS_LOCKED : SPM_STATUS_OK;
        end
    end

    assign mem_v_o     = issue;
    assign mem_w_o     = (op_q[rd_ptr_q] == SPM_OP_WRITE) && !locked;  // locked write is a no-op
    assign mem_addr_o  = addr_q[rd_ptr_q];
    assign mem_wdata_o = wdata_q[rd_ptr_q];
    assign mem_mask_o  = mask_q[rd_ptr_q];
    assign credit_o    = issue;            // slot freed as the head leaves
    assign reject_o    = issue && locked;

    assign resp_v_o      = resp_v_q;
    assign resp_op_o     = resp_op_q;
    assign resp_status_o = resp_status_q;
    assign resp_rdata_o  = mem_rdata_i;

endmodule

// ==== verilog/spm_top.sv ====
// banked scratchpad top level, joins the request controller, config registers and banked memory
`timescale 1ns/1ns

module spm_top #(
    parameter int  DATA_W               = spm_pkg::SPM_DATA_W,
    parameter int  ELS                  = spm_pkg::SPM_ELS,
    parameter int  NUM_WIDTH_BANKS      = 2,
    parameter int  NUM_DEPTH_BANKS      = 4,
    parameter int  DEPTH_BANK_START_IDX = 0,
    parameter int  CREDITS              = spm_pkg::SPM_CREDITS,
    localparam int ADDR_W               = $clog2(ELS),
    localparam int MASK_W               = DATA_W / 8
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // request port, credit based
    input  logic                 req_v_i,
    input  spm_pkg::spm_op_e     req_op_i,
    input  logic [ADDR_W-1:0]    req_addr_i,
    input  logic [DATA_W-1:0]    req_wdata_i,
    input  logic [MASK_W-1:0]    req_mask_i,
    output logic                 credit_o,
    // response port, no back-pressure
    output logic                 resp_v_o,
    output spm_pkg::spm_op_e     resp_op_o,
    output spm_pkg::spm_status_e resp_status_o,
    output logic [DATA_W-1:0]    resp_rdata_o,
    // config port
    input  logic                 cfg_we_i,
    input  logic [ADDR_W-1:0]    cfg_lock_i,
    output logic [15:0]          cfg_reject_cnt_o
);

    logic [ADDR_W-1:0] lock_limit;
    logic              reject;
    logic              mem_v;
    logic              mem_w;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [MASK_W-1:0] mem_mask;
    logic [DATA_W-1:0] mem_rdata;  // one cycle behind mem_v

    spm_req_ctrl #(
        .DATA_W (DATA_W), .ELS (ELS), .CREDITS (CREDITS)
    ) u_req_ctrl (
        .clk_i, .rst_n_i, .req_v_i, .req_op_i, .req_addr_i, .req_wdata_i, .req_mask_i,
        .lock_limit_i (lock_limit), .mem_rdata_i (mem_rdata), .credit_o,
        .reject_o (reject), .mem_v_o (mem_v), .mem_w_o (mem_w), .mem_addr_o (mem_addr),
        .mem_wdata_o (mem_wdata), .mem_mask_o (mem_mask),
        .resp_v_o, .resp_op_o, .resp_status_o, .resp_rdata_o
    );

    spm_cfg_regs #(.ELS (ELS)) u_cfg_regs (
        .clk_i, .rst_n_i, .cfg_we_i, .cfg_lock_i, .reject_i (reject),
        .lock_limit_o (lock_limit), .cfg_reject_cnt_o
    );

    spm_banked_mem #(
        .DATA_W (DATA_W), .ELS (ELS), .NUM_WIDTH_BANKS (NUM_WIDTH_BANKS),
        .NUM_DEPTH_BANKS (NUM_DEPTH_BANKS), .DEPTH_BANK_START_IDX (DEPTH_BANK_START_IDX)
    ) u_mem (
        .clk_i, .rst_n_i, .v_i (mem_v), .w_i (mem_w), .addr_i (mem_addr),
        .data_i (mem_wdata), .mask_i (mem_mask), .data_o (mem_rdata)
    );

endmodule
